// File: common/cpu_pkg.sv
// Shared widths, encodings and pipeline register layouts, imported by every core module
`default_nettype none

package cpu_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////////////////////////
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam logic [REG_ADDR_W-1:0] LINK_REG = 5'd31;  // JAL return address

    //////////////////////////////////////////////////////////////////////
    // Instruction encodings
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00, OP_J     = 6'h02, OP_JAL   = 6'h03,
        OP_BEQ     = 6'h04, OP_BNE   = 6'h05,
        OP_ADDI    = 6'h08, OP_ADDIU = 6'h09, OP_SLTI  = 6'h0a, OP_SLTIU = 6'h0b,
        OP_ANDI    = 6'h0c, OP_ORI   = 6'h0d, OP_XORI  = 6'h0e, OP_LUI   = 6'h0f,
        OP_LB      = 6'h20, OP_LH    = 6'h21, OP_LW    = 6'h23,
        OP_LBU     = 6'h24, OP_LHU   = 6'h25,
        OP_SB      = 6'h28, OP_SH    = 6'h29, OP_SW    = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL  = 6'h00, FN_SRL  = 6'h02, FN_JR   = 6'h08,
        FN_ADD  = 6'h20, FN_ADDU = 6'h21, FN_SUB  = 6'h22, FN_SUBU = 6'h23,
        FN_SLT  = 6'h2a, FN_SLTU = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SLT,
        ALU_SLTU, ALU_AND, ALU_OR, ALU_XOR, ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {SZ_BYTE, SZ_HALF, SZ_WORD} access_size_e;
    typedef enum logic [1:0] {BR_BEQ, BR_BNE} branch_type_e;

    //////////////////////////////////////////////////////////////////////
    // Stage registers
    //////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] insn;
        logic [XLEN-1:0] pc_plus4;
    } if_id_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc_plus4;
        logic [XLEN-1:0]       op_a;         // rs value
        logic [XLEN-1:0]       op_b;         // rt value
        logic [XLEN-1:0]       imm;          // Extended immediate
        logic [25:0]           jump_target;
        alu_op_e               alu_op;
        logic [4:0]            shamt;
        logic                  op2_sel;      // 1 selects imm
        logic                  is_branch;
        branch_type_e          branch_type;
        logic                  is_jump;      // J and JAL
        logic                  is_jal;
        logic                  is_jr;
        logic                  mem_read;
        logic                  mem_write;
        access_size_e          size;
        logic                  sign_ext;
        logic                  reg_write;
        logic [REG_ADDR_W-1:0] rd;
        logic                  illegal;
    } id_ex_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       result;       // ALU result, link value or address
        logic [XLEN-1:0]       store_data;
        logic                  mem_read;
        logic                  mem_write;
        access_size_e          size;
        logic                  sign_ext;
        logic                  reg_write;
        logic [REG_ADDR_W-1:0] rd;
    } ex_mw_t;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } wb_t;

endpackage

`default_nettype wire

// File: execute/alu.sv
// Arithmetic, logic, shift and compare unit used by the execute stage
`timescale 1ns/1ps
`default_nettype none

module alu import cpu_pkg::*; (
    input  wire alu_op_e         op,
    input  wire logic [XLEN-1:0] a,
    input  wire logic [XLEN-1:0] b,
    input  wire logic [4:0]      shamt,
    output      logic [XLEN-1:0] result,
    output      logic            zero     // Branch compare
);

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = b << shamt;                       // Shifts act on rt
            ALU_SRL:  result = b >> shamt;
            ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU: result = {31'b0, a < b};
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_LUI:  result = {b[15:0], 16'h0};
            default:  result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

`default_nettype wire

// File: execute/branch_resolve.sv
// Branch and jump decision with target address, evaluated in the execute stage
`timescale 1ns/1ps
`default_nettype none

module branch_resolve import cpu_pkg::*; (
    input  wire logic            valid,
    input  wire logic            is_branch,
    input  wire branch_type_e    branch_type,
    input  wire logic            zero,
    input  wire logic            is_jump,
    input  wire logic            is_jr,
    input  wire logic [XLEN-1:0] pc_plus4,
    input  wire logic [XLEN-1:0] imm,
    input  wire logic [25:0]     jump_target,
    input  wire logic [XLEN-1:0] rs_value,
    output      logic            taken,
    output      logic [XLEN-1:0] target
);

    logic cond;

    assign cond  = (branch_type == BR_BEQ) ? zero : !zero;   // On rs - rt
    assign taken = valid && (is_jump || is_jr || (is_branch && cond));

    assign target = is_jr   ? rs_value :
                    is_jump ? {pc_plus4[31:28], jump_target, 2'b00} :
                              pc_plus4 + {imm[XLEN-3:0], 2'b00};   // Word offset

endmodule

`default_nettype wire

// File: execute/ex_stage.sv
// Execute stage: ALU and branch resolve side by side, redirect and the EX/MW register
`timescale 1ns/1ps
`default_nettype none

module ex_stage import cpu_pkg::*; (
    input  wire logic            clk,
    input  wire logic            reset,
    input  wire id_ex_t          id_ex,
    output      ex_mw_t          ex_mw,
    output      logic            redirect,
    output      logic [XLEN-1:0] redirect_pc,
    output      logic            illegal_insn
);

    logic [XLEN-1:0] op2;
    logic [XLEN-1:0] alu_result;
    logic            zero;
    ex_mw_t          ex_mw_d;

    assign op2 = id_ex.op2_sel ? id_ex.imm : id_ex.op_b;

    alu u_alu (
        .op(id_ex.alu_op), .a(id_ex.op_a), .b(op2), .shamt(id_ex.shamt),
        .result(alu_result), .zero
    );

    branch_resolve u_branch (
        .valid(id_ex.valid), .is_branch(id_ex.is_branch), .branch_type(id_ex.branch_type),
        .zero, .is_jump(id_ex.is_jump), .is_jr(id_ex.is_jr), .pc_plus4(id_ex.pc_plus4),
        .imm(id_ex.imm), .jump_target(id_ex.jump_target), .rs_value(id_ex.op_a),
        .taken(redirect), .target(redirect_pc)
    );

    assign illegal_insn = id_ex.valid && id_ex.illegal;  // One cycle in EX

    always_comb begin
        ex_mw_d            = '0;
        ex_mw_d.valid      = id_ex.valid;
        ex_mw_d.result     = id_ex.is_jal ? id_ex.pc_plus4 : alu_result;  // Link value
        ex_mw_d.store_data = id_ex.op_b;
        ex_mw_d.mem_read   = id_ex.mem_read;
        ex_mw_d.mem_write  = id_ex.mem_write;
        ex_mw_d.size       = id_ex.size;
        ex_mw_d.sign_ext   = id_ex.sign_ext;
        ex_mw_d.reg_write  = id_ex.reg_write;
        ex_mw_d.rd         = id_ex.rd;
    end

    always_ff @(posedge clk) begin
        if (reset)
            ex_mw <= '0;
        else
            ex_mw <= ex_mw_d;   // Never stalled
    end

endmodule

`default_nettype wire

// File: src/fetch_stage.sv
// Fetch stage holding the PC, driving the instruction address and filling IF/ID
`timescale 1ns/1ps
`default_nettype none

module fetch_stage import cpu_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = 32'h8002_0000
) (
    input  wire logic            clk,
    input  wire logic            reset,
    input  wire logic            stall,
    input  wire logic            redirect,
    input  wire logic [XLEN-1:0] redirect_pc,
    output      logic [XLEN-1:0] insn_addr,
    input  wire logic [XLEN-1:0] insn_data,
    output      if_id_t          if_id
);

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc_plus4;

    assign insn_addr = pc;        // Combinational ROM read
    assign pc_plus4  = pc + 32'd4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc    <= RESET_PC;
            if_id <= '0;
        end else if (redirect) begin  // Redirect wins over stall
            pc    <= redirect_pc;
            if_id <= '0;              // Squash the wrong-path word
        end else if (!stall) begin
            pc    <= pc_plus4;
            if_id <= '{valid: 1'b1, insn: insn_data, pc_plus4: pc_plus4};
        end
        // Stall holds PC and IF/ID
    end

endmodule

`default_nettype wire

// File: src/decode_stage.sv
// Decode stage: control decode, register read, RAW interlock and the ID/EX register
`timescale 1ns/1ps
`default_nettype none

module decode_stage import cpu_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire if_id_t                if_id,
    output      logic [REG_ADDR_W-1:0] rs_addr,
    output      logic [REG_ADDR_W-1:0] rt_addr,
    input  wire logic [XLEN-1:0]       rs_data,
    input  wire logic [XLEN-1:0]       rt_data,
    input  wire ex_mw_t                ex_mw,      // Destination in MW
    input  wire logic                  redirect,
    output      logic                  stall,
    output      id_ex_t                id_ex
);

    logic [XLEN-1:0] insn;
    opcode_e         opcode;
    funct_e          funct;
    id_ex_t          dec;                   // Next ID/EX contents
    logic            use_rs, use_rt;        // Sources really read
    logic            ex_live, mw_live;
    logic            rs_hit, rt_hit;

    assign insn    = if_id.insn;
    assign opcode  = opcode_e'(insn[31:26]);
    assign funct   = funct_e'(insn[5:0]);
    assign rs_addr = insn[25:21];
    assign rt_addr = insn[20:16];

    //////////////////////////////////////////////////////////////////////
    // Instruction decode
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        dec             = '0;                      // Illegal and unknown act as no-ops
        use_rs          = 1'b0;
        use_rt          = 1'b0;
        dec.valid       = if_id.valid;
        dec.pc_plus4    = if_id.pc_plus4;
        dec.op_a        = rs_data;
        dec.op_b        = rt_data;
        dec.imm         = {{16{insn[15]}}, insn[15:0]};
        dec.jump_target = insn[25:0];
        dec.shamt       = insn[10:6];
        dec.rd          = rt_addr;                 // I-type destination
        case (opcode)
            OP_SPECIAL: begin
                dec.rd        = insn[15:11];
                dec.reg_write = 1'b1;
                use_rs        = 1'b1;
                use_rt        = 1'b1;
                case (funct)
                    FN_SLL: begin
                        dec.alu_op = ALU_SLL;
                        use_rs     = 1'b0;         // Shifts read rt only
                    end
                    FN_SRL: begin
                        dec.alu_op = ALU_SRL;
                        use_rs     = 1'b0;
                    end
                    FN_JR: begin
                        dec.is_jr     = 1'b1;
                        dec.reg_write = 1'b0;
                        use_rt        = 1'b0;
                    end
                    FN_ADD, FN_ADDU: dec.alu_op = ALU_ADD;
                    FN_SUB, FN_SUBU: dec.alu_op = ALU_SUB;
                    FN_SLT:          dec.alu_op = ALU_SLT;
                    FN_SLTU:         dec.alu_op = ALU_SLTU;
                    default: begin                 // MULT, DIV, SRA and the rest
                        dec.illegal   = 1'b1;
                        dec.reg_write = 1'b0;
                        use_rs        = 1'b0;
                        use_rt        = 1'b0;
                    end
                endcase
            end
            OP_J:   dec.is_jump = 1'b1;
            OP_JAL: begin
                dec.is_jump   = 1'b1;
                dec.is_jal    = 1'b1;
                dec.reg_write = 1'b1;
                dec.rd        = LINK_REG;
            end
            OP_BEQ, OP_BNE: begin
                dec.is_branch   = 1'b1;
                dec.alu_op      = ALU_SUB;         // Zero flag decides
                dec.branch_type = (opcode == OP_BEQ) ? BR_BEQ : BR_BNE;
                use_rs          = 1'b1;
                use_rt          = 1'b1;
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                dec.op2_sel   = 1'b1;
                dec.reg_write = 1'b1;
                use_rs        = 1'b1;
                case (opcode)
                    OP_SLTI:  dec.alu_op = ALU_SLT;
                    OP_SLTIU: dec.alu_op = ALU_SLTU;    // Sign-extended, compared unsigned
                    OP_ANDI:  dec.alu_op = ALU_AND;
                    OP_ORI:   dec.alu_op = ALU_OR;
                    OP_XORI:  dec.alu_op = ALU_XOR;
                    OP_LUI:   dec.alu_op = ALU_LUI;
                    default:  dec.alu_op = ALU_ADD;
                endcase
                if (opcode inside {OP_ANDI, OP_ORI, OP_XORI})
                    dec.imm = {16'h0, insn[15:0]};      // Logic ops zero-extend
            end
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: begin
                dec.op2_sel   = 1'b1;                   // Address = rs + imm
                dec.mem_read  = 1'b1;
                dec.reg_write = 1'b1;
                dec.sign_ext  = (opcode == OP_LB) || (opcode == OP_LH);
                dec.size      = (opcode == OP_LW) ? SZ_WORD :
                                (opcode inside {OP_LH, OP_LHU}) ? SZ_HALF : SZ_BYTE;
                use_rs        = 1'b1;
            end
            OP_SB, OP_SH, OP_SW: begin
                dec.op2_sel   = 1'b1;
                dec.mem_write = 1'b1;
                dec.size      = (opcode == OP_SW) ? SZ_WORD :
                                (opcode == OP_SH) ? SZ_HALF : SZ_BYTE;
                use_rs        = 1'b1;
                use_rt        = 1'b1;                   // Store data
            end
            default: dec.illegal = 1'b1;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // RAW interlock against EX and MW destinations
    //////////////////////////////////////////////////////////////////////
    assign ex_live = id_ex.valid && id_ex.reg_write;
    assign mw_live = ex_mw.valid && ex_mw.reg_write;
    assign rs_hit  = use_rs && (rs_addr != '0) &&
                     ((ex_live && rs_addr == id_ex.rd) || (mw_live && rs_addr == ex_mw.rd));
    assign rt_hit  = use_rt && (rt_addr != '0) &&
                     ((ex_live && rt_addr == id_ex.rd) || (mw_live && rt_addr == ex_mw.rd));
    assign stall   = if_id.valid && (rs_hit || rt_hit);

    always_ff @(posedge clk) begin
        if (reset || redirect || stall || !if_id.valid)
            id_ex <= '0;                                // Bubble
        else
            id_ex <= dec;
    end

endmodule

`default_nettype wire

// File: src/reg_file.sv
// 32-entry register file, two read ports with write-through from the retire record
`timescale 1ns/1ps
`default_nettype none

module reg_file import cpu_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic [REG_ADDR_W-1:0] rs_addr,
    input  wire logic [REG_ADDR_W-1:0] rt_addr,
    output      logic [XLEN-1:0]       rs_data,
    output      logic [XLEN-1:0]       rt_data,
    input  wire wb_t                   wb
);

    logic [XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (wb.valid && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // Register 0 reads zero, a same-cycle write bypasses the array
    assign rs_data = (rs_addr == '0) ? '0 :
                     (wb.valid && wb.rd == rs_addr) ? wb.data : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 :
                     (wb.valid && wb.rd == rt_addr) ? wb.data : regs[rt_addr];

endmodule

`default_nettype wire

// File: src/mem_wb_stage.sv
// Memory and write-back stage: big-endian data memory, load extension, retire record
`timescale 1ns/1ps
`default_nettype none

module mem_wb_stage import cpu_pkg::*; #(
    parameter int DMEM_WORDS = 1024
) (
    input  wire logic   clk,
    input  wire logic   reset,
    input  wire ex_mw_t ex_mw,
    output      wb_t    wb
);

    localparam int IDX_W = $clog2(DMEM_WORDS);

    logic [XLEN-1:0]  dmem [DMEM_WORDS];
    logic [IDX_W-1:0] word_idx;
    logic [1:0]       off;                 // Byte offset, 0 is the MSB lane
    logic [XLEN-1:0]  rd_word;
    logic [XLEN-1:0]  byte_word, half_word;
    logic [XLEN-1:0]  load_val;
    logic [XLEN-1:0]  st_data;             // Store data replicated to all lanes
    logic [3:0]       be;                  // Lane enables, bit 3 is bits 31:24

    assign word_idx = ex_mw.result[IDX_W+1:2];
    assign off      = ex_mw.result[1:0];
    assign rd_word  = dmem[word_idx];

    //////////////////////////////////////////////////////////////////////
    // Stores
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        case (ex_mw.size)
            SZ_BYTE: begin
                st_data = {4{ex_mw.store_data[7:0]}};
                be      = 4'b1000 >> off;
            end
            SZ_HALF: begin
                st_data = {2{ex_mw.store_data[15:0]}};
                be      = off[1] ? 4'b0011 : 4'b1100;
            end
            default: begin
                st_data = ex_mw.store_data;
                be      = 4'b1111;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DMEM_WORDS; i++)
                dmem[i] <= '0;
        end else if (ex_mw.valid && ex_mw.mem_write) begin
            for (int b = 0; b < 4; b++)
                if (be[b])
                    dmem[word_idx][8*b +: 8] <= st_data[8*b +: 8];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Loads and result select
    //////////////////////////////////////////////////////////////////////
    assign byte_word = rd_word >> {~off, 3'b000};       // Selected byte to bits 7:0
    assign half_word = rd_word >> {~off[1], 4'b0000};

    always_comb begin
        case (ex_mw.size)
            SZ_BYTE: load_val = ex_mw.sign_ext ? {{24{byte_word[7]}}, byte_word[7:0]}
                                               : {24'h0, byte_word[7:0]};
            SZ_HALF: load_val = ex_mw.sign_ext ? {{16{half_word[15]}}, half_word[15:0]}
                                               : {16'h0, half_word[15:0]};
            default: load_val = rd_word;
        endcase
    end

    assign wb.valid = ex_mw.valid && ex_mw.reg_write && (ex_mw.rd != '0);  // No r0 strobe
    assign wb.rd    = ex_mw.rd;
    assign wb.data  = ex_mw.mem_read ? load_val : ex_mw.result;

endmodule

`default_nettype wire

// File: src/cpu_core.sv
// Four-stage core top level; testbench drives the instruction port and watches wb
`timescale 1ns/1ps
`default_nettype none

module cpu_core import cpu_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC   = 32'h8002_0000,
    parameter int              DMEM_WORDS = 1024
) (
    input  wire logic            clk,
    input  wire logic            reset,
    output      logic [XLEN-1:0] insn_addr,
    input  wire logic [XLEN-1:0] insn_data,
    output      wb_t             wb,           // One strobe per register write
    output      logic            illegal_insn
);

    if_id_t                if_id;
    id_ex_t                id_ex;
    ex_mw_t                ex_mw;
    logic                  stall;          // RAW interlock from decode
    logic                  redirect;       // Taken branch or jump in EX
    logic [XLEN-1:0]       redirect_pc;
    logic [REG_ADDR_W-1:0] rs_addr, rt_addr;
    logic [XLEN-1:0]       rs_data, rt_data;

    fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
        .clk, .reset, .stall, .redirect, .redirect_pc,
        .insn_addr, .insn_data, .if_id
    );

    decode_stage u_decode (
        .clk, .reset, .if_id, .rs_addr, .rt_addr, .rs_data, .rt_data,
        .ex_mw, .redirect, .stall, .id_ex
    );

    reg_file u_reg_file (
        .clk, .reset, .rs_addr, .rt_addr, .rs_data, .rt_data, .wb
    );

    ex_stage u_ex (
        .clk, .reset, .id_ex, .ex_mw, .redirect, .redirect_pc, .illegal_insn
    );

    mem_wb_stage #(.DMEM_WORDS(DMEM_WORDS)) u_mem_wb (
        .clk, .reset, .ex_mw, .wb
    );

endmodule

`default_nettype wire

// File: testbench/tb_cpu_core.sv
// Testbench for cpu_core that runs the golden program and checks each write-back in order
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_core import cpu_pkg::*; ();

    localparam logic [XLEN-1:0] RESET_PC = 32'h8002_0000;
    localparam int CLK_PERIOD         = 4;
    localparam int RESET_CYCLES       = 4;
    localparam int IDLE_CYCLES        = 20;    // Quiet tail after the last write-back
    localparam int WATCHDOG_PER_ENTRY = 50;
    localparam int GOLDEN_WORDS       = 128;
    localparam int PROG_WORDS         = 64;    // Program area at the start of the file
    localparam int EXP_BASE           = 64;    // First (register, value) pair
    localparam int ILLEGAL_SLOT       = 126;   // Expected illegal pulses
    localparam int COUNT_SLOT         = 127;   // Expected write-back count

    logic            clk;
    logic            reset;
    logic [XLEN-1:0] insn_addr;
    logic [XLEN-1:0] insn_data;
    wb_t             wb;
    logic            illegal_insn;

    logic [XLEN-1:0] golden [GOLDEN_WORDS];
    logic            golden_loaded;
    int              n_expected;
    int              n_illegal_exp;
    int              n_seen;          // Write-backs observed so far
    int              n_illegal;       // illegal_insn pulses observed
    int              mismatches;
    int              failures;        // Errors other than wrong values

    cpu_core #(.RESET_PC(RESET_PC), .DMEM_WORDS(1024)) u_dut (
        .clk, .reset, .insn_addr, .insn_data, .wb, .illegal_insn
    );

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////
    // Instruction ROM view of the program area with NOP elsewhere
    function automatic logic [XLEN-1:0] rom_word(input logic [XLEN-1:0] addr);
        logic [XLEN-1:0] offset;
        offset = addr - RESET_PC;
        if (offset < 32'(4 * PROG_WORDS) && offset[1:0] == 2'b00)
            return golden[offset[7:2]];
        else
            return '0;        // SLL r0 acts as NOP
    endfunction

    task automatic check_value(input string what, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("Mismatch at time %0t: %s is %h, expected %h", $time, what, got, exp);
            mismatches++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Clock and instruction port
    //////////////////////////////////////////////////////////////////////
    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        #1;                                  // PC has settled by now
        insn_data = rom_word(insn_addr);
    end

    //////////////////////////////////////////////////////////////////////
    // Write-back and illegal pulse monitor
    //////////////////////////////////////////////////////////////////////
    always @(negedge clk) begin               // Away from the register updates
        if (!reset) begin
            if (illegal_insn)
                n_illegal++;
            if (wb.valid) begin
                if (n_seen < n_expected) begin
                    check_value("wb.rd", 32'(wb.rd), golden[EXP_BASE + 2 * n_seen]);
                    check_value("wb.data", wb.data, golden[EXP_BASE + 2 * n_seen + 1]);
                end else begin
                    $display("Unexpected write-back at time %0t: r%0d = %h after the last entry",
                             $time, wb.rd, wb.data);
                    failures++;
                end
                n_seen++;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        reset         = 1'b1;
        insn_data     = '0;
        golden_loaded = 1'b0;
        n_seen        = 0;
        n_illegal     = 0;
        mismatches    = 0;
        failures      = 0;
        for (int i = 0; i < GOLDEN_WORDS; i++)
            golden[i] = '0;                   // Unused program words read as NOP
        $readmemh("testbench/cpu_core_golden.hex", golden);
        n_illegal_exp = int'(golden[ILLEGAL_SLOT]);
        n_expected    = int'(golden[COUNT_SLOT]);
        golden_loaded = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;
        check_value("insn_addr after reset", insn_addr, RESET_PC);  // First fetch

        wait (n_seen >= n_expected);
        repeat (IDLE_CYCLES) @(posedge clk);   // Squashed writes would show up here
        check_value("illegal pulse count", 32'(n_illegal), 32'(n_illegal_exp));

        $display("Errors: %0d mismatches, %0d other failures (%0d of %0d write-backs seen)",
                 mismatches, failures, n_seen, n_expected);
        if (mismatches == 0 && failures == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    // Watchdog budget scales with the number of expected write-backs
    initial begin
        wait (golden_loaded);
        repeat (RESET_CYCLES + WATCHDOG_PER_ENTRY * n_expected) @(posedge clk);
        $display("Watchdog expired: only %0d of %0d write-backs seen", n_seen, n_expected);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: cpu_core.f
common/cpu_pkg.sv
execute/alu.sv
execute/branch_resolve.sv
execute/ex_stage.sv
src/fetch_stage.sv
src/decode_stage.sv
src/reg_file.sv
src/mem_wb_stage.sv
src/cpu_core.sv
testbench/tb_cpu_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the core and its testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing -Wno-fatal --top-module tb_cpu_core -f cpu_core.f \
    && ./obj_dir/Vtb_cpu_core | tee sim.log \
    && grep -qx "Result: PASSED" sim.log \
    && echo "Simulation run passed" \
    || { echo "Simulation run failed"; exit 1; }

// File: testbench/cpu_core_golden.hex
// Program words from RESET_PC at @000, then expected write-backs as (register, value)
// pairs at @040 in program order, then expected illegal pulses and write-back count at @07e
@000
20010005 3c021234 34425678 00411822  // ADDI r1, LUI/ORI r2, SUB r3
2004ffff 0081282a 0081302b 3047ff0f  // ADDI r4 -1, SLT r5, SLTU r6, ANDI r7
382800f0 00014900 00025202 200b0100  // XORI r8, SLL r9, SRL r10, base r11
ad620000 a5640006 a1680005 8d6c0004  // SW, SH, SB, LW r12
856d0006 956e0004 816f0005 91700001  // LH r13, LHU r14, LB r15, LBU r16
10210002 20110bad 20110bad 14210001  // BEQ taken over two writes, BNE not taken
20120012 0c00801d 20130019 0800801f  // ADDI r18, JAL sub, ADDI r19, J over block
20140bad 20150021 03e00008 00210018  // Skipped write, sub body, JR r31, MULT
20000007 20160022                    // Write to r0, ADDI r22
@040
01 00000005  02 12340000  02 12345678  03 12345673
04 ffffffff  05 00000001  06 00000000  07 00005608
08 000000f5  09 00000050  0a 00123456  0b 00000100
0c 00f5ffff  0d ffffffff  0e 000000f5  0f fffffff5
10 00000034  12 00000012  1f 80020068  15 00000021
13 00000019  16 00000022
@07e
00000001 00000016
